// File: mnist_overlay.f
source/mnist_overlay_pkg.sv
source/frame_binarizer.sv
source/display_timing.sv
source/overlay_mixer.sv
source/mnist_overlay_top.sv
sim/mnist_overlay_properties.sv
sim/tb_mnist_overlay.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_mnist_overlay -f mnist_overlay.f -o tb_mnist_overlay

out=$(./obj_dir/tb_mnist_overlay 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
    exit 0
fi
exit 1

// File: sim/tb_mnist_overlay.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mnist_overlay;

    // ----------------------------------------------------------------------
    // small screen and camera geometry
    // ----------------------------------------------------------------------

    localparam int H_ACTIVE = 160;
    localparam int H_TOTAL = 200;
    localparam int H_SYNC = 8;
    localparam int V_ACTIVE = 96;
    localparam int V_TOTAL = 110;
    localparam int V_SYNC = 2;
    localparam int SAMPLE_SHIFT = 1;
    localparam int CELL_SHIFT = 1;
    localparam int IMG_X = 20;
    localparam int IMG_Y = 2;
    localparam int CLASS_X = 2;
    localparam int CLASS_Y = 20;

    localparam int CAM_W = 64;                   // camera frame size
    localparam int CAM_H = 64;
    localparam int STEP = 1 << SAMPLE_SHIFT;     // camera pixels per sample
    localparam int DIM = mnist_overlay_pkg::IMG_DIM;
    localparam int NCLS = mnist_overlay_pkg::CLASS_COUNT;
    localparam int NBITS = DIM * DIM;
    localparam int RUN_FRAMES = 4;               // display frames checked
    localparam int TIMEOUT_CYCLES = 6 * H_TOTAL * V_TOTAL;

    localparam int T_RESET = 0;
    localparam int T_GEOM = 1;
    localparam int T_BG = 2;
    localparam int T_IMG = 3;
    localparam int T_CLS = 4;
    localparam int T_HS = 5;
    localparam int N_TESTS = 6;

    logic                           video_clk;
    logic                           rst_n;
    logic                           cam_vsync;
    logic                           cam_de;
    mnist_overlay_pkg::pixel_word_t cam_data;
    logic [NCLS-1:0]                class_bits;
    logic                           out_hs, out_vs, out_de;
    logic [7:0]                     out_r, out_g, out_b;

    mnist_overlay_top #(
        .H_ACTIVE     (H_ACTIVE),
        .H_TOTAL      (H_TOTAL),
        .H_SYNC       (H_SYNC),
        .V_ACTIVE     (V_ACTIVE),
        .V_TOTAL      (V_TOTAL),
        .V_SYNC       (V_SYNC),
        .SAMPLE_SHIFT (SAMPLE_SHIFT),
        .CELL_SHIFT   (CELL_SHIFT),
        .IMG_X        (IMG_X),
        .IMG_Y        (IMG_Y),
        .CLASS_X      (CLASS_X),
        .CLASS_Y      (CLASS_Y)
    ) i_mnist_overlay_top (
        .video_clk  (video_clk),
        .rst_n      (rst_n),
        .cam_vsync  (cam_vsync),
        .cam_de     (cam_de),
        .cam_data   (cam_data),
        .class_bits (class_bits),
        .out_hs     (out_hs),
        .out_vs     (out_vs),
        .out_de     (out_de),
        .out_r      (out_r),
        .out_g      (out_g),
        .out_b      (out_b)
    );

    initial begin
        video_clk = 1'b0;
        forever #4 video_clk = ~video_clk;       // 125 MHz
    end

    // ----------------------------------------------------------------------
    // model state and helpers
    // ----------------------------------------------------------------------

    logic [15:0]      cam_lfsr = 16'd8;          // camera stream generator
    logic [15:0]      cls_lfsr = 16'd8;          // class bits generator
    logic [NBITS-1:0] cam_frames[$];             // binarized frames, camera order
    logic [NBITS-1:0] disp_img = '0;             // image read back from screen
    logic [NBITS-1:0] disp_seen = '0;
    logic [NCLS-1:0]  class_exp = '0;            // class bits latched at last vs
    int               err_cnt[N_TESTS];
    int               chk_cnt[N_TESTS];
    int               mx = 0;                    // screen coords from out_de/out_vs
    int               my = 0;
    int               hpos = -1;                 // line position, -1 before first line
    int               frames_done = 0;
    int               cur_frame = 0;             // queue entry now on screen
    int               new_images = 0;
    logic             prev_de = 1'b0;
    logic             prev_vs = 1'b0;
    logic             reset_done = 1'b0;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(inout logic [15:0] s, input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            s = lfsr_step(s);
            v = {v[14:0], s[0]};                 // one step per bit
        end
    endtask

    function automatic logic is_dark(input logic [15:0] w);
        mnist_overlay_pkg::pixel_word_t pix;
        pix.raw = w;
        return (int'(pix.rgb565.red) + int'(pix.rgb565.green) + int'(pix.rgb565.blue))
               < mnist_overlay_pkg::DARK_THRESHOLD;
    endfunction

    function automatic string test_label(input int t);
        case (t)
            T_RESET: return "reset_state";
            T_GEOM:  return "frame_geometry";
            T_BG:    return "background";
            T_IMG:   return "image_window";
            T_CLS:   return "class_window";
            default: return "handshake_order";
        endcase
    endfunction

    task automatic value_check(input int t, input logic [23:0] exp, input logic [23:0] act);
        chk_cnt[t]++;
        if (exp != act) begin
            err_cnt[t]++;
            if (err_cnt[t] <= 10)                // keep the log short
                $display("Error %s: expected %0h actual %0h", test_label(t), exp, act);
        end
    endtask

    task automatic condition_check(input int t, input logic ok, input string what);
        chk_cnt[t]++;
        if (!ok) begin
            err_cnt[t]++;
            $display("%s: %s", test_label(t), what);
        end
    endtask

    task automatic test_line(input int t);
        if (err_cnt[t] == 0)
            $display("%s passed, %0d checks", test_label(t), chk_cnt[t]);
        else
            $display("%s FAILED, %0d of %0d checks wrong", test_label(t), err_cnt[t],
                     chk_cnt[t]);
    endtask

    // ----------------------------------------------------------------------
    // per pixel expectation
    // ----------------------------------------------------------------------

    task automatic check_pixel(input int px, input int py);
        int          icx, icy, ccx, ccy;
        logic [9:0]  iidx;
        logic [3:0]  cidx;
        logic [23:0] act;
        icx = px >> CELL_SHIFT;
        icy = py >> CELL_SHIFT;
        ccx = px >> (CELL_SHIFT + 1);            // class cells are double size
        ccy = py >> (CELL_SHIFT + 1);
        act = {out_r, out_g, out_b};
        if (icx >= IMG_X && icx < IMG_X + DIM && icy >= IMG_Y && icy < IMG_Y + DIM) begin
            iidx = 10'((icy - IMG_Y) * DIM + (icx - IMG_X));
            value_check(T_IMG, {3{{8{out_r[0]}}}}, act);     // pure black or white
            if (disp_seen[iidx])
                value_check(T_IMG, {3{{8{disp_img[iidx]}}}}, act);
            disp_seen[iidx] = 1'b1;
            disp_img[iidx] = out_r[0];
        end else if (ccy == CLASS_Y && ccx >= CLASS_X && ccx < CLASS_X + NCLS) begin
            cidx = 4'(ccx - CLASS_X);
            value_check(T_CLS, {3{{8{class_exp[cidx]}}}}, act);
        end else begin
            value_check(T_BG, {px[7:0], py[7:0], 8'hff}, act);
        end
    endtask

    // whole frame against the camera queue
    task automatic close_frame();
        int match;
        match = -1;
        condition_check(T_IMG, disp_seen == '1, "some image cells were never drawn");
        for (int i = 0; i < cam_frames.size(); i++) begin
            if (cam_frames[i] == disp_img)
                match = i;
        end
        condition_check(T_IMG, match >= 0, "displayed image matches no binarized camera frame");
        if (match >= 0) begin
            condition_check(T_HS, match >= cur_frame, "an older camera frame came back on screen");
            if (match > cur_frame) begin
                new_images++;
                cur_frame = match;
            end
        end
        disp_seen = '0;
        disp_img = '0;
    endtask

    // ----------------------------------------------------------------------
    // output monitor, sampled mid cycle
    // ----------------------------------------------------------------------

    always @(negedge video_clk) begin
        if (reset_done) begin
            if (out_de) begin
                check_pixel(mx, my);
                mx++;
            end else begin
                value_check(T_BG, 24'h0, {out_r, out_g, out_b});   // black in blanking
            end
            if (out_de && !prev_de)
                hpos = 0;                        // line starts with de
            else if (hpos >= 0)
                hpos = (hpos + 1) % H_TOTAL;
            if (hpos >= 0)                       // hs right after the active part
                value_check(T_GEOM, 24'(hpos >= H_ACTIVE && hpos < H_ACTIVE + H_SYNC),
                            24'(out_hs));
            if (prev_de && !out_de) begin
                value_check(T_GEOM, 24'(H_ACTIVE), 24'(mx));      // line just ended
                mx = 0;
                my++;
            end
            if (out_vs && !prev_vs) begin
                value_check(T_GEOM, 24'(V_ACTIVE), 24'(my));
                close_frame();
                class_exp = class_bits;          // mixer took these at this vs
                my = 0;
                frames_done++;
            end
            prev_de = out_de;
            prev_vs = out_vs;
        end
    end

    // ----------------------------------------------------------------------
    // camera stream
    // ----------------------------------------------------------------------

    initial begin
        logic [15:0]      w;
        logic [15:0]      r;
        logic [NBITS-1:0] img;
        cam_vsync = 1'b0;
        cam_de = 1'b0;
        cam_data = '0;
        cam_frames.push_back('0);                // screen before the first handoff
        wait (reset_done);
        forever begin
            img = '0;
            for (int cy = 0; cy < CAM_H; cy++) begin
                for (int cx = 0; cx < CAM_W; cx++) begin
                    draw_bits(cam_lfsr, 16, w);
                    draw_bits(cam_lfsr, 1, r);
                    if (r[0])
                        w = w & 16'h1863;        // ink pixel, all fields small
                    if (cx % STEP == 0 && cy % STEP == 0 && cx / STEP < DIM && cy / STEP < DIM)
                        img[10'((cy / STEP) * DIM + cx / STEP)] = is_dark(w);
                    @(posedge video_clk);
                    cam_de <= 1'b1;
                    cam_data <= w;
                end
                draw_bits(cam_lfsr, 2, r);
                repeat (1 + r[1:0]) begin
                    @(posedge video_clk);
                    cam_de <= 1'b0;              // row gap
                end
            end
            cam_frames.push_back(img);
            draw_bits(cam_lfsr, 3, r);
            @(posedge video_clk);
            cam_vsync <= 1'b1;                   // frame end, handoff may start
            repeat (8 + r[2:0]) @(posedge video_clk);
            cam_vsync <= 1'b0;
            repeat (2) @(posedge video_clk);
        end
    end

    // new class bits once vs has ended
    initial begin
        logic [15:0] v;
        logic        vs_seen;
        class_bits = '0;
        vs_seen = 1'b0;
        wait (reset_done);
        forever begin
            @(posedge video_clk);
            if (vs_seen && !out_vs) begin
                draw_bits(cls_lfsr, 10, v);
                class_bits <= v[9:0];
            end
            vs_seen = out_vs;
        end
    end

    // ----------------------------------------------------------------------
    // reset, run, report
    // ----------------------------------------------------------------------

    initial begin
        int failed_tests;
        int total_err;
        int total_chk;
        failed_tests = 0;
        total_err = 0;
        total_chk = 0;
        rst_n = 1'b0;
        repeat (5) begin
            @(negedge video_clk);
            value_check(T_RESET, 24'h0, {21'h0, out_hs, out_vs, out_de});
        end
        @(posedge video_clk);
        rst_n <= 1'b1;
        repeat (2) begin
            @(negedge video_clk);
            value_check(T_RESET, 24'h0, {21'h0, out_hs, out_vs, out_de});
        end
        reset_done = 1'b1;
        test_line(T_RESET);
        wait (frames_done >= RUN_FRAMES);
        condition_check(T_HS, new_images >= 2, "fewer than two new images reached the display");
        for (int t = T_GEOM; t < N_TESTS; t++)
            test_line(t);
        for (int t = 0; t < N_TESTS; t++) begin
            total_err += err_cnt[t];
            total_chk += chk_cnt[t];
            if (err_cnt[t] != 0)
                failed_tests++;
        end
        $display("tests %0d passed %0d failed, checks %0d, errors %0d",
                 N_TESTS - failed_tests, failed_tests, total_chk, total_err);
        if (total_err == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    // run limit
    initial begin
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge video_clk);
            cycles++;
        end
        $display("timeout: %0d display frames not finished after %0d cycles",
                 RUN_FRAMES, cycles);
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/mnist_overlay_properties.sv
`timescale 1ns/1ps
`default_nettype none

module mnist_overlay_properties (
    input logic                                                          video_clk,
    input logic                                                          rst_n,
    input logic                                                          img_req,
    input logic                                                          img_ack,
    input logic [mnist_overlay_pkg::IMG_DIM*mnist_overlay_pkg::IMG_DIM-1:0] img_data,
    input logic                                                          out_vs,
    input logic                                                          out_de
);

    // ----------------------------------------------------------------------
    // image handoff
    // ----------------------------------------------------------------------

    ack_needs_req: assert property (@(posedge video_clk) disable iff (!rst_n)
        $rose(img_ack) |-> img_req)
        else $error("img_ack rose while img_req was low");

    // request held with frozen data until answered
    req_held: assert property (@(posedge video_clk) disable iff (!rst_n)
        img_req && !img_ack |=> img_req && $stable(img_data))
        else $error("img_req dropped or img_data changed before img_ack");

    // ----------------------------------------------------------------------
    // output syncs
    // ----------------------------------------------------------------------

    no_de_in_vs: assert property (@(posedge video_clk) disable iff (!rst_n)
        !(out_de && out_vs))
        else $error("out_de high during out_vs");

endmodule

bind overlay_mixer mnist_overlay_properties i_mnist_overlay_properties (
    .video_clk (video_clk),
    .rst_n     (rst_n),
    .img_req   (img_req),
    .img_ack   (img_ack),
    .img_data  (img_data),
    .out_vs    (out_vs),
    .out_de    (out_de)
);

`default_nettype wire

// File: source/mnist_overlay_top.sv
`timescale 1ns/1ps
`default_nettype none

module mnist_overlay_top #(
    parameter int H_ACTIVE     = 1280,          // 720p frame
    parameter int H_TOTAL      = 1650,
    parameter int H_SYNC       = 40,
    parameter int V_ACTIVE     = 720,
    parameter int V_TOTAL      = 750,
    parameter int V_SYNC       = 5,
    parameter int SAMPLE_SHIFT = 3,             // 224 px camera area to 28
    parameter int CELL_SHIFT   = 4,             // 16 px image cells
    parameter int IMG_X        = 50,
    parameter int IMG_Y        = 1,
    parameter int CLASS_X      = 1,
    parameter int CLASS_Y      = 18
) (
    input  logic                                    video_clk,
    input  logic                                    rst_n,
    input  logic                                    cam_vsync,
    input  logic                                    cam_de,
    input  mnist_overlay_pkg::pixel_word_t          cam_data,
    input  logic [mnist_overlay_pkg::CLASS_COUNT-1:0] class_bits,
    output logic                                    out_hs,
    output logic                                    out_vs,
    output logic                                    out_de,
    output logic [7:0]                              out_r,
    output logic [7:0]                              out_g,
    output logic [7:0]                              out_b
);

    // ----------------------------------------------------------------------
    // inter stage wires
    // ----------------------------------------------------------------------

    logic                                             img_req;
    logic                                             img_ack;
    logic [mnist_overlay_pkg::IMG_DIM*mnist_overlay_pkg::IMG_DIM-1:0] img_data;

    logic                                             disp_hs, disp_vs, disp_de;
    logic [mnist_overlay_pkg::COORD_W-1:0]            disp_x, disp_y;

    frame_binarizer #(
        .SAMPLE_SHIFT (SAMPLE_SHIFT)
    ) i_frame_binarizer (
        .video_clk (video_clk),
        .rst_n     (rst_n),
        .cam_vsync (cam_vsync),
        .cam_de    (cam_de),
        .cam_data  (cam_data),
        .img_ack   (img_ack),
        .img_req   (img_req),
        .img_data  (img_data)
    );

    display_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .H_SYNC   (H_SYNC),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL),
        .V_SYNC   (V_SYNC)
    ) i_display_timing (
        .video_clk (video_clk),
        .rst_n     (rst_n),
        .hs        (disp_hs),
        .vs        (disp_vs),
        .de        (disp_de),
        .x         (disp_x),
        .y         (disp_y)
    );

    overlay_mixer #(
        .CELL_SHIFT (CELL_SHIFT),
        .IMG_X      (IMG_X),
        .IMG_Y      (IMG_Y),
        .CLASS_X    (CLASS_X),
        .CLASS_Y    (CLASS_Y)
    ) i_overlay_mixer (
        .video_clk  (video_clk),
        .rst_n      (rst_n),
        .hs         (disp_hs),
        .vs         (disp_vs),
        .de         (disp_de),
        .x          (disp_x),
        .y          (disp_y),
        .img_req    (img_req),
        .img_data   (img_data),
        .class_bits (class_bits),
        .img_ack    (img_ack),
        .out_hs     (out_hs),
        .out_vs     (out_vs),
        .out_de     (out_de),
        .out_r      (out_r),
        .out_g      (out_g),
        .out_b      (out_b)
    );

endmodule

`default_nettype wire

// File: source/overlay_mixer.sv
`timescale 1ns/1ps
`default_nettype none

module overlay_mixer #(
    parameter int CELL_SHIFT = 4,               // image cell is 2^n pixels
    parameter int IMG_X      = 50,              // image origin in image cells
    parameter int IMG_Y      = 1,
    parameter int CLASS_X    = 1,               // class origin in class cells
    parameter int CLASS_Y    = 18
) (
    input  logic                                 video_clk,
    input  logic                                 rst_n,
    input  logic                                 hs,
    input  logic                                 vs,
    input  logic                                 de,
    input  logic [mnist_overlay_pkg::COORD_W-1:0] x,
    input  logic [mnist_overlay_pkg::COORD_W-1:0] y,
    input  logic                                 img_req,
    input  logic [mnist_overlay_pkg::IMG_DIM*mnist_overlay_pkg::IMG_DIM-1:0] img_data,
    input  logic [mnist_overlay_pkg::CLASS_COUNT-1:0] class_bits,
    output logic                                 img_ack,
    output logic                                 out_hs,
    output logic                                 out_vs,
    output logic                                 out_de,
    output logic [7:0]                           out_r,
    output logic [7:0]                           out_g,
    output logic [7:0]                           out_b
);

    localparam int CW    = mnist_overlay_pkg::COORD_W;
    localparam int DIM   = mnist_overlay_pkg::IMG_DIM;
    localparam int NCLS  = mnist_overlay_pkg::CLASS_COUNT;
    localparam int IDX_W = $clog2(DIM * DIM);   // image bit index
    localparam int CLS_W = $clog2(NCLS);        // class bit index

    // ----------------------------------------------------------------------
    // frame start capture and handoff, ack side
    // ----------------------------------------------------------------------

    logic                 vs_d;
    logic                 vs_rise;
    logic [DIM*DIM-1:0]   img_q;                 // image on screen
    logic [NCLS-1:0]      class_q;               // class bits on screen

    assign vs_rise = vs & ~vs_d;                 // vertical blank begins

    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            vs_d    <= 1'b0;
            img_ack <= 1'b0;
            img_q   <= '0;                       // blank image until first handoff
            class_q <= '0;
        end else begin
            vs_d <= vs;
            if (vs_rise) begin
                class_q <= class_bits;
                if (img_req && !img_ack) begin
                    img_q   <= img_data;         // take image for next frame
                    img_ack <= 1'b1;
                end
            end
            if (img_ack && !img_req)
                img_ack <= 1'b0;                 // req gone, close the cycle
        end
    end

    // ----------------------------------------------------------------------
    // window decode
    // ----------------------------------------------------------------------

    logic [CW-1:0]    img_cx, img_cy;            // coords in image cells
    logic [CW-1:0]    cls_cx, cls_cy;            // coords in class cells
    logic [CW-1:0]    img_row, img_col;          // offsets inside image window
    logic [IDX_W-1:0] img_idx;
    logic [CLS_W-1:0] cls_idx;
    logic             in_img;
    logic             in_cls;

    assign img_cx = x >> CELL_SHIFT;
    assign img_cy = y >> CELL_SHIFT;
    assign cls_cx = x >> (CELL_SHIFT + 1);       // class cells twice as big
    assign cls_cy = y >> (CELL_SHIFT + 1);

    assign in_img = (img_cx >= CW'(IMG_X)) && (img_cx < CW'(IMG_X + DIM))
                 && (img_cy >= CW'(IMG_Y)) && (img_cy < CW'(IMG_Y + DIM));
    assign in_cls = (cls_cx >= CW'(CLASS_X)) && (cls_cx < CW'(CLASS_X + NCLS))
                 && (cls_cy == CW'(CLASS_Y));    // single row

    assign img_row = img_cy - CW'(IMG_Y);
    assign img_col = img_cx - CW'(IMG_X);
    assign img_idx = IDX_W'(img_row * CW'(DIM) + img_col);   // row major
    assign cls_idx = CLS_W'(cls_cx - CW'(CLASS_X));

    // ----------------------------------------------------------------------
    // colour select
    // ----------------------------------------------------------------------

    logic [7:0] mix_r, mix_g, mix_b;

    always_comb begin
        mix_r = x[7:0];                          // gradient background
        mix_g = y[7:0];
        mix_b = 8'hff;
        if (in_img) begin
            mix_r = {8{img_q[img_idx]}};
            mix_g = {8{img_q[img_idx]}};
            mix_b = {8{img_q[img_idx]}};
        end else if (in_cls) begin
            mix_r = {8{class_q[cls_idx]}};
            mix_g = {8{class_q[cls_idx]}};
            mix_b = {8{class_q[cls_idx]}};
        end
    end

    // syncs and colour leave on the same edge
    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            out_hs <= 1'b0;
            out_vs <= 1'b0;
            out_de <= 1'b0;
        end else begin
            out_hs <= hs;
            out_vs <= vs;
            out_de <= de;
        end
    end

    always_ff @(posedge video_clk) begin
        out_r <= de ? mix_r : 8'h00;             // black in blanking
        out_g <= de ? mix_g : 8'h00;
        out_b <= de ? mix_b : 8'h00;
    end

endmodule

`default_nettype wire

// File: source/display_timing.sv
`timescale 1ns/1ps
`default_nettype none

module display_timing #(
    parameter int H_ACTIVE = 1280,              // visible pixels per line
    parameter int H_TOTAL  = 1650,              // line length incl blanking
    parameter int H_SYNC   = 40,                // hs width right after active
    parameter int V_ACTIVE = 720,               // visible lines
    parameter int V_TOTAL  = 750,               // frame length in lines
    parameter int V_SYNC   = 5                  // vs width in lines
) (
    input  logic                                 video_clk,
    input  logic                                 rst_n,
    output logic                                 hs,
    output logic                                 vs,
    output logic                                 de,
    output logic [mnist_overlay_pkg::COORD_W-1:0] x,
    output logic [mnist_overlay_pkg::COORD_W-1:0] y
);

    localparam int CW = mnist_overlay_pkg::COORD_W;

    // ----------------------------------------------------------------------
    // free running counters
    // ----------------------------------------------------------------------

    logic [CW-1:0] h_cnt;
    logic [CW-1:0] v_cnt;
    logic          line_end;

    assign line_end = (h_cnt == CW'(H_TOTAL - 1));

    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (line_end) begin
                h_cnt <= '0;
                if (v_cnt == CW'(V_TOTAL - 1))
                    v_cnt <= '0;                 // frame wrap
                else
                    v_cnt <= v_cnt + CW'(1);
            end else begin
                h_cnt <= h_cnt + CW'(1);
            end
        end
    end

    // ----------------------------------------------------------------------
    // registered sync and coordinates
    // ----------------------------------------------------------------------

    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            hs <= 1'b0;
            vs <= 1'b0;
            de <= 1'b0;
            x  <= '0;
            y  <= '0;
        end else begin
            de <= (h_cnt < CW'(H_ACTIVE)) && (v_cnt < CW'(V_ACTIVE));
            hs <= (h_cnt >= CW'(H_ACTIVE)) && (h_cnt < CW'(H_ACTIVE + H_SYNC));
            vs <= (v_cnt >= CW'(V_ACTIVE)) && (v_cnt < CW'(V_ACTIVE + V_SYNC));
            x  <= h_cnt;                         // only meaningful with de
            y  <= v_cnt;
        end
    end

endmodule

`default_nettype wire

// File: source/frame_binarizer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_binarizer #(
    parameter int SAMPLE_SHIFT = 3              // sample every 2^n pixels
) (
    input  logic                          video_clk,
    input  logic                          rst_n,
    input  logic                          cam_vsync,   // high in camera v blank
    input  logic                          cam_de,      // one valid pixel per cycle
    input  mnist_overlay_pkg::pixel_word_t cam_data,
    input  logic                          img_ack,
    output logic                          img_req,
    output logic [mnist_overlay_pkg::IMG_DIM*mnist_overlay_pkg::IMG_DIM-1:0] img_data
);

    localparam int CW     = mnist_overlay_pkg::COORD_W;
    localparam int NBITS  = mnist_overlay_pkg::IMG_DIM * mnist_overlay_pkg::IMG_DIM;
    localparam logic [CW-1:0] SAMPLE_MASK = CW'((1 << SAMPLE_SHIFT) - 1);

    // ----------------------------------------------------------------------
    // camera coordinates
    // ----------------------------------------------------------------------

    logic [CW-1:0] x_cnt;                        // index of current pixel in row
    logic [CW-1:0] y_cnt;                        // row index since vsync
    logic          de_d;                         // de one cycle back
    logic          vsync_d;                      // vsync one cycle back
    logic          vsync_rise;

    assign vsync_rise = cam_vsync & ~vsync_d;    // end of camera frame

    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            x_cnt   <= '0;
            y_cnt   <= '0;
            de_d    <= 1'b0;
            vsync_d <= 1'b0;
        end else begin
            de_d    <= cam_de;
            vsync_d <= cam_vsync;
            if (cam_vsync) begin
                x_cnt <= '0;                     // new frame coming
                y_cnt <= '0;
            end else begin
                if (cam_de)
                    x_cnt <= x_cnt + CW'(1);
                else
                    x_cnt <= '0;                 // row gap
                if (de_d && !cam_de)
                    y_cnt <= y_cnt + CW'(1);     // row just ended
            end
        end
    end

    // ----------------------------------------------------------------------
    // decimation and threshold
    // ----------------------------------------------------------------------

    logic          on_grid;                      // pixel lands on a sample point
    logic          in_image;                     // scaled coords inside 28x28
    logic          sample_en;
    logic [6:0]    rgb_sum;                      // max 31+63+31
    logic          dark;

    assign on_grid   = ((x_cnt & SAMPLE_MASK) == '0) && ((y_cnt & SAMPLE_MASK) == '0);
    assign in_image  = ((x_cnt >> SAMPLE_SHIFT) < CW'(mnist_overlay_pkg::IMG_DIM))
                    && ((y_cnt >> SAMPLE_SHIFT) < CW'(mnist_overlay_pkg::IMG_DIM));
    assign sample_en = cam_de && !cam_vsync && on_grid && in_image;

    assign rgb_sum = 7'(cam_data.rgb565.red)
                   + 7'(cam_data.rgb565.green)
                   + 7'(cam_data.rgb565.blue);
    assign dark    = rgb_sum < 7'(mnist_overlay_pkg::DARK_THRESHOLD);

    logic [NBITS-1:0] bin_shr;                   // image being collected

    // shift in from the top, first sample ends up in bit 0
    always_ff @(posedge video_clk) begin
        if (sample_en)
            bin_shr <= {dark, bin_shr[NBITS-1:1]};
    end

    // ----------------------------------------------------------------------
    // handoff, request side
    // ----------------------------------------------------------------------

    logic          launch;                       // frame end with link idle

    assign launch = vsync_rise && !img_req && !img_ack;   // busy frame dropped

    always_ff @(posedge video_clk or negedge rst_n) begin
        if (!rst_n) begin
            img_req <= 1'b0;
        end else if (launch) begin
            img_req <= 1'b1;
        end else if (img_req && img_ack) begin
            img_req <= 1'b0;                     // phase 3 of four
        end
    end

    // stable while img_req is high
    always_ff @(posedge video_clk) begin
        if (launch)
            img_data <= bin_shr;
    end

endmodule

`default_nettype wire

// File: source/mnist_overlay_pkg.sv
`default_nettype none

// shared types and constants for the overlay path
package mnist_overlay_pkg;

    // ----------------------------------------------------------------------
    // camera pixel word
    // ----------------------------------------------------------------------

    // rgb565 fields as the sensor packs them, blue in the top bits
    typedef struct packed {
        logic [4:0] blue;                   // bits 15..11
        logic [5:0] green;                  // bits 10..5
        logic [4:0] red;                    // bits 4..0
    } rgb565_t;

    // one 16 bit word, seen raw or split into colour fields
    typedef union packed {
        logic [15:0] raw;                   // word as it leaves the sensor
        rgb565_t     rgb565;                // decoded colour view
    } pixel_word_t;

    // ----------------------------------------------------------------------
    // image and overlay sizes
    // ----------------------------------------------------------------------

    localparam int IMG_DIM = 28;            // binary image side in cells

    localparam int CLASS_COUNT = 10;        // class cells, also class_bits width

    // r+g+b below this counts as ink
    localparam int DARK_THRESHOLD = 30;

    localparam int COORD_W = 12;            // all pixel coordinate counters

endpackage

`default_nettype wire
